/* hw/ddr_cmd_pkg.sv */
`default_nettype none

package ddr_cmd_pkg;

    // opcodes as {ras, cas, we}, active high
    localparam logic [2:0] OP_NOP = 3'b000;        // idle slot
    localparam logic [2:0] OP_ACT = 3'b100;        // activate row
    localparam logic [2:0] OP_RD  = 3'b010;        // read burst
    localparam logic [2:0] OP_WR  = 3'b011;        // write burst
    localparam logic [2:0] OP_PRE = 3'b101;        // precharge bank

    // command word layout
    localparam int OPC_LSB    = 29;                // opcode [31:29]
    localparam int BANK_LSB   = 26;                // bank [28:26]
    localparam int ADDR_LSB   = 11;                // address [25:11]
    localparam int ADDR_BITS  = 15;
    localparam int DONE_BIT   = 10;                // last word of a sequence
    localparam int PAUSE_BITS = 10;                // pause [9:0]

    // pauses in controller clocks after each command
    localparam logic [PAUSE_BITS-1:0] T_RCD_PAUSE = 10'd5;   // act to first burst
    localparam logic [PAUSE_BITS-1:0] T_RP_PAUSE  = 10'd5;   // read pre to next act
    localparam logic [PAUSE_BITS-1:0] T_WR_PAUSE  = 10'd12;  // write recovery + trp
    localparam logic [PAUSE_BITS-1:0] RW_PAUSE    = 10'd0;   // back to back bursts

    localparam int SEL_ADDR_BIT = 14;              // late/early select in addr field

    // act + up to 2**n bursts + pre
    function automatic int MAX_SEQ_WORDS(input int num_xfer_bits);
        return (1 << num_xfer_bits) + 2;
    endfunction

    // pack one command word from its fields
    function automatic logic [31:0] cmd_word(input logic [2:0]            opc,
                                             input logic [2:0]            bank,
                                             input logic [ADDR_BITS-1:0]  addr,
                                             input logic                  done,
                                             input logic [PAUSE_BITS-1:0] pause);
        logic [31:0] w;
        w                       = '0;
        w[OPC_LSB +: 3]         = opc;
        w[BANK_LSB +: 3]        = bank;
        w[ADDR_LSB +: ADDR_BITS] = addr;
        w[DONE_BIT]             = done;
        w[PAUSE_BITS-1:0]       = pause;
        return w;
    endfunction

endpackage

`default_nettype wire

/* hw/cmd_encod_linear_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_encod_linear_rd #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6,       // 0 in num128_in means 2**NUM_XFER_BITS
    parameter bit RSEL           = 1'b1     // late/early read select
) (
    input  wire                      clk,
    input  wire                      mrst,
    input  wire [2:0]                bank_in,
    input  wire [ADDRESS_NUMBER-1:0] row_in,
    input  wire [COLADDR_NUMBER-4:0] start_col,        // in 8-bursts
    input  wire [NUM_XFER_BITS-1:0]  num128_in,
    input  wire                      skip_next_page_in,
    input  wire                      start,
    output logic [31:0]              enc_cmd,
    output logic                     enc_wr,
    output logic                     enc_done
);

    logic [2:0]                bank_r;              // latched request
    logic [COLADDR_NUMBER-4:0] col_r;               // current burst column, wraps
    logic [NUM_XFER_BITS:0]    left_r;              // bursts still to emit
    logic                      skip_r;
    logic                      busy;                // act sent, pre not yet
    logic [ADDRESS_NUMBER-1:0] burst_addr;
    logic [ADDRESS_NUMBER-1:0] pre_addr;

    always_comb begin
        burst_addr                             = '0;
        burst_addr[COLADDR_NUMBER-1:0]         = {col_r, 3'b000};  // column in 16-bit words
        burst_addr[ddr_cmd_pkg::SEL_ADDR_BIT]  = RSEL;
    end

    assign pre_addr = {{(ADDRESS_NUMBER-1){1'b0}}, skip_r};       // a0 keeps next page

    // control
    always_ff @(posedge clk) begin
        if (mrst) begin
            busy     <= 1'b0;
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            enc_wr   <= 1'b1;                          // act goes out next cycle
            enc_done <= 1'b0;
        end else if (busy) begin
            enc_wr   <= 1'b1;
            enc_done <= (left_r == '0);                // pre is the last word
            busy     <= (left_r != '0);
        end else begin
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end
    end

    // request latch and word build
    always_ff @(posedge clk) begin
        if (start) begin
            bank_r  <= bank_in;
            col_r   <= start_col;
            skip_r  <= skip_next_page_in;
            left_r  <= (num128_in == '0) ? {1'b1, {NUM_XFER_BITS{1'b0}}} : {1'b0, num128_in};
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_ACT, bank_in, row_in, 1'b0,
                                             ddr_cmd_pkg::T_RCD_PAUSE);
        end else if (busy && (left_r != '0)) begin
            col_r   <= col_r + 1'b1;                   // mod 128
            left_r  <= left_r - 1'b1;
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_RD, bank_r, burst_addr, 1'b0,
                                             ddr_cmd_pkg::RW_PAUSE);
        end else if (busy) begin
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_PRE, bank_r, pre_addr, 1'b1,
                                             ddr_cmd_pkg::T_RP_PAUSE);
        end else begin
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_NOP, bank_r, '0, 1'b0, '0);
        end
    end

endmodule

`default_nettype wire

/* hw/cmd_encod_linear_wr.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_encod_linear_wr #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6,       // 0 in num128_in means 2**NUM_XFER_BITS
    parameter bit WSEL           = 1'b0     // late/early write select
) (
    input  wire                      clk,
    input  wire                      mrst,
    input  wire [2:0]                bank_in,
    input  wire [ADDRESS_NUMBER-1:0] row_in,
    input  wire [COLADDR_NUMBER-4:0] start_col,        // in 8-bursts
    input  wire [NUM_XFER_BITS-1:0]  num128_in,
    input  wire                      skip_next_page_in,
    input  wire                      start,
    output logic [31:0]              enc_cmd,
    output logic                     enc_wr,
    output logic                     enc_done
);

    logic [2:0]                bank_r;
    logic [COLADDR_NUMBER-4:0] col_r;               // wraps within the page
    logic [NUM_XFER_BITS:0]    left_r;              // write bursts remaining
    logic                      skip_r;
    logic                      busy;
    logic [ADDRESS_NUMBER-1:0] burst_addr;
    logic [ADDRESS_NUMBER-1:0] pre_addr;

    always_comb begin
        burst_addr                             = '0;
        burst_addr[COLADDR_NUMBER-1:0]         = {col_r, 3'b000};
        burst_addr[ddr_cmd_pkg::SEL_ADDR_BIT]  = WSEL;  // write timing select
    end

    assign pre_addr = {{(ADDRESS_NUMBER-1){1'b0}}, skip_r};

    always_ff @(posedge clk) begin
        if (mrst) begin
            busy     <= 1'b0;
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            enc_wr   <= 1'b1;
            enc_done <= 1'b0;
        end else if (busy) begin
            enc_wr   <= 1'b1;
            enc_done <= (left_r == '0);                // with pre word
            busy     <= (left_r != '0);
        end else begin
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end
    end

    // same walk as the read side, wr opcode and write recovery on pre
    always_ff @(posedge clk) begin
        if (start) begin
            bank_r  <= bank_in;
            col_r   <= start_col;
            skip_r  <= skip_next_page_in;
            left_r  <= (num128_in == '0) ? {1'b1, {NUM_XFER_BITS{1'b0}}} : {1'b0, num128_in};
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_ACT, bank_in, row_in, 1'b0,
                                             ddr_cmd_pkg::T_RCD_PAUSE);
        end else if (busy && (left_r != '0)) begin
            col_r   <= col_r + 1'b1;
            left_r  <= left_r - 1'b1;
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_WR, bank_r, burst_addr, 1'b0,
                                             ddr_cmd_pkg::RW_PAUSE);
        end else if (busy) begin
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_PRE, bank_r, pre_addr, 1'b1,
                                             ddr_cmd_pkg::T_WR_PAUSE);
        end else begin
            enc_cmd <= ddr_cmd_pkg::cmd_word(ddr_cmd_pkg::OP_NOP, bank_r, '0, 1'b0, '0);
        end
    end

endmodule

`default_nettype wire

/* hw/cmd_encod_linear_rw.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_encod_linear_rw #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6,
    parameter bit RSEL           = 1'b1,
    parameter bit WSEL           = 1'b0
) (
    input  wire                      clk,
    input  wire                      mrst,
    input  wire [2:0]                bank_in,
    input  wire [ADDRESS_NUMBER-1:0] row_in,
    input  wire [COLADDR_NUMBER-4:0] start_col,
    input  wire [NUM_XFER_BITS-1:0]  num128_in,
    input  wire                      skip_next_page_in,
    input  wire                      start_rd,
    input  wire                      start_wr,
    output logic                     start,             // 1 clk after start_rd/start_wr
    output logic [31:0]              enc_cmd,
    output logic                     enc_wr,
    output logic                     enc_done
);

    logic [31:0] enc_cmd_rd;
    logic        enc_wr_rd;
    logic        enc_done_rd;
    logic [31:0] enc_cmd_wr;
    logic        enc_wr_wr;
    logic        enc_done_wr;
    logic        select_wr;                            // last started was the writer

    cmd_encod_linear_rd #(
        .ADDRESS_NUMBER (ADDRESS_NUMBER),
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS),
        .RSEL           (RSEL)
    ) cmd_encod_linear_rd_i (
        .clk               (clk),
        .mrst              (mrst),
        .bank_in           (bank_in),
        .row_in            (row_in),
        .start_col         (start_col),
        .num128_in         (num128_in),
        .skip_next_page_in (skip_next_page_in),
        .start             (start_rd),
        .enc_cmd           (enc_cmd_rd),
        .enc_wr            (enc_wr_rd),
        .enc_done          (enc_done_rd)
    );

    cmd_encod_linear_wr #(
        .ADDRESS_NUMBER (ADDRESS_NUMBER),
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS),
        .WSEL           (WSEL)
    ) cmd_encod_linear_wr_i (
        .clk               (clk),
        .mrst              (mrst),
        .bank_in           (bank_in),
        .row_in            (row_in),
        .start_col         (start_col),
        .num128_in         (num128_in),
        .skip_next_page_in (skip_next_page_in),
        .start             (start_wr),
        .enc_cmd           (enc_cmd_wr),
        .enc_wr            (enc_wr_wr),
        .enc_done          (enc_done_wr)
    );

    always_ff @(posedge clk) begin
        if (mrst) begin
            start     <= 1'b0;
            select_wr <= 1'b0;
            enc_wr    <= 1'b0;
            enc_done  <= 1'b0;
        end else begin
            start    <= start_rd || start_wr;
            enc_wr   <= select_wr ? enc_wr_wr : enc_wr_rd;
            enc_done <= select_wr ? enc_done_wr : enc_done_rd;
            if (start_rd) begin
                select_wr <= 1'b0;
            end else if (start_wr) begin
                select_wr <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        enc_cmd <= select_wr ? enc_cmd_wr : enc_cmd_rd;  // payload, follows select
    end

endmodule

`default_nettype wire

/* hw/cmd_seq_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_seq_buf #(
    parameter int BUF_DEPTH_LOG = 7,
    parameter int NUM_XFER_BITS = 6         // sizes the room needed for one sequence
) (
    input  wire         clk,
    input  wire         mrst,
    input  wire  [31:0] enc_cmd,
    input  wire         enc_wr,
    input  wire         enc_done,
    input  wire         cmd_credit,                    // one slot granted by sequencer
    output logic [31:0] cmd_word,
    output logic        cmd_valid,
    output logic        enough_room                    // a full sequence fits
);

    localparam int DEPTH       = 1 << BUF_DEPTH_LOG;
    localparam int CREDIT_BITS = 16;
    localparam logic [BUF_DEPTH_LOG:0] MAX_FILL =
        (BUF_DEPTH_LOG + 1)'(DEPTH - ddr_cmd_pkg::MAX_SEQ_WORDS(NUM_XFER_BITS));

    logic [31:0]              mem [DEPTH];
    logic [BUF_DEPTH_LOG-1:0] wr_ptr;
    logic [BUF_DEPTH_LOG-1:0] rd_ptr;
    logic [BUF_DEPTH_LOG:0]   fill;                    // words held
    logic [CREDIT_BITS-1:0]   credits;                 // unspent credits
    logic [CREDIT_BITS-1:0]   credits_avail;           // incl. this cycle's grant
    logic                     pop;

    assign credits_avail = credits + CREDIT_BITS'(cmd_credit);
    assign pop           = (credits_avail != '0) && (fill != '0);
    assign enough_room   = (fill <= MAX_FILL);

    always_ff @(posedge clk) begin
        if (enc_wr) begin
            // done flag restamped from the encoder strobe
            mem[wr_ptr] <= {enc_cmd[31:ddr_cmd_pkg::DONE_BIT+1], enc_done,
                            enc_cmd[ddr_cmd_pkg::DONE_BIT-1:0]};
        end
        if (pop) begin
            cmd_word <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            credits   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= pop;                          // one word per spent credit
            if (enc_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill    <= fill + (BUF_DEPTH_LOG + 1)'(enc_wr) - (BUF_DEPTH_LOG + 1)'(pop);
            credits <= credits_avail - CREDIT_BITS'(pop);
        end
    end

endmodule

`default_nettype wire

/* hw/linear_rw_top.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_rw_top #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6,
    parameter bit RSEL           = 1'b1,
    parameter bit WSEL           = 1'b0,
    parameter int BUF_DEPTH_LOG  = 7
) (
    input  wire                      clk,
    input  wire                      mrst,
    input  wire [2:0]                bank_in,
    input  wire [ADDRESS_NUMBER-1:0] row_in,
    input  wire [COLADDR_NUMBER-4:0] start_col,
    input  wire [NUM_XFER_BITS-1:0]  num128_in,
    input  wire                      skip_next_page_in,
    input  wire                      start_rd,
    input  wire                      start_wr,
    input  wire                      cmd_credit,
    output logic                     start,
    output logic [31:0]              cmd_word,
    output logic                     cmd_valid,
    output logic                     seq_ready,         // may start a new request
    output logic                     seq_done           // last word of a sequence encoded
);

    logic [31:0] enc_cmd;
    logic        enc_wr;
    logic        enc_done;
    logic        enough_room;
    logic        busy;                                 // sequence in flight
    logic        running;                              // low during reset only

    cmd_encod_linear_rw #(
        .ADDRESS_NUMBER (ADDRESS_NUMBER),
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS),
        .RSEL           (RSEL),
        .WSEL           (WSEL)
    ) cmd_encod_linear_rw_i (
        .clk               (clk),
        .mrst              (mrst),
        .bank_in           (bank_in),
        .row_in            (row_in),
        .start_col         (start_col),
        .num128_in         (num128_in),
        .skip_next_page_in (skip_next_page_in),
        .start_rd          (start_rd),
        .start_wr          (start_wr),
        .start             (start),
        .enc_cmd           (enc_cmd),
        .enc_wr            (enc_wr),
        .enc_done          (enc_done)
    );

    cmd_seq_buf #(
        .BUF_DEPTH_LOG (BUF_DEPTH_LOG),
        .NUM_XFER_BITS (NUM_XFER_BITS)
    ) cmd_seq_buf_i (
        .clk         (clk),
        .mrst        (mrst),
        .enc_cmd     (enc_cmd),
        .enc_wr      (enc_wr),
        .enc_done    (enc_done),
        .cmd_credit  (cmd_credit),
        .cmd_word    (cmd_word),
        .cmd_valid   (cmd_valid),
        .enough_room (enough_room)
    );

    always_ff @(posedge clk) begin
        if (mrst) begin
            busy    <= 1'b0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (start_rd || start_wr) begin
                busy <= 1'b1;
            end else if (enc_done) begin
                busy <= 1'b0;                          // pre word is in the buffer
            end
        end
    end

    assign seq_ready = running && enough_room && !busy;
    assign seq_done  = enc_done;

endmodule

`default_nettype wire

/* verif/linear_rw_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_rw_chk #(
    parameter int BUF_DEPTH_LOG = 7,
    parameter int CREDIT_BITS   = 16
) (
    input  wire                     clk,
    input  wire                     mrst,
    input  wire                     cmd_credit,       // grant arriving this cycle
    input  wire                     enc_wr,           // word written into the FIFO
    input  wire                     pop,              // word leaving the FIFO
    input  wire                     cmd_valid,
    input  wire [BUF_DEPTH_LOG:0]   fill
);

    localparam int DEPTH = 1 << BUF_DEPTH_LOG;
    localparam logic [BUF_DEPTH_LOG:0] DEPTH_W = (BUF_DEPTH_LOG + 1)'(DEPTH);

    logic [CREDIT_BITS-1:0] unspent;                  // grants not yet answered by cmd_valid

    always_ff @(posedge clk) begin
        if (mrst) begin
            unspent <= '0;
        end else begin
            unspent <= unspent + CREDIT_BITS'(cmd_credit) - CREDIT_BITS'(cmd_valid);
        end
    end

    // every cmd_valid answers a grant taken at an earlier edge
    a_valid_needs_credit: assert property (@(posedge clk) disable iff (mrst)
        cmd_valid |-> (unspent != '0))
        else $error("cmd_valid issued with no credit outstanding");

    // write into a full FIFO with nothing leaving
    a_no_overflow: assert property (@(posedge clk) disable iff (mrst)
        (enc_wr && !pop) |-> (fill < DEPTH_W))
        else $error("command FIFO overflow");

    a_fill_bounded: assert property (@(posedge clk) disable iff (mrst)
        fill <= DEPTH_W)
        else $error("FIFO occupancy above its depth");

endmodule

`default_nettype wire

/* verif/tb_linear_rw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_linear_rw;

    localparam int ADDRESS_NUMBER = 15;
    localparam int COLADDR_NUMBER = 10;
    localparam int NUM_XFER_BITS  = 6;
    localparam bit RSEL           = 1'b1;
    localparam bit WSEL           = 1'b0;
    localparam int BUF_DEPTH_LOG  = 7;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;   // 200 cycles per test

    logic        clk = 1'b0;
    logic        mrst;
    logic [2:0]  bank_in;
    logic [14:0] row_in;
    logic [6:0]  start_col;
    logic [5:0]  num128_in;
    logic        skip_next_page_in;
    logic        start_rd;
    logic        start_wr;
    logic        cmd_credit = 1'b0;                     // owned by the credit driver
    logic        start;
    logic [31:0] cmd_word;
    logic        cmd_valid;
    logic        seq_ready;
    logic        seq_done;

    logic [31:0] exp_q[$];                              // reference model words, in order
    logic [31:0] exp_w;
    int          errors = 0;
    int          tests_failed = 0;
    int          test_err_start = 0;
    int          starts = 0;
    int          dones = 0;
    int          valids = 0;
    int          credits_given = 0;
    int          cycles = 0;
    int          credit_mode = 0;                       // 0 none, 1 as needed, 2 random gaps,
                                                        // 3 only until room reopens

    always #2 clk = ~clk;

    linear_rw_top #(
        .ADDRESS_NUMBER (ADDRESS_NUMBER),
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS),
        .RSEL           (RSEL),
        .WSEL           (WSEL),
        .BUF_DEPTH_LOG  (BUF_DEPTH_LOG)
    ) uut (
        .clk               (clk),
        .mrst              (mrst),
        .bank_in           (bank_in),
        .row_in            (row_in),
        .start_col         (start_col),
        .num128_in         (num128_in),
        .skip_next_page_in (skip_next_page_in),
        .start_rd          (start_rd),
        .start_wr          (start_wr),
        .cmd_credit        (cmd_credit),
        .start             (start),
        .cmd_word          (cmd_word),
        .cmd_valid         (cmd_valid),
        .seq_ready         (seq_ready),
        .seq_done          (seq_done)
    );

    bind cmd_seq_buf linear_rw_chk #(
        .BUF_DEPTH_LOG (BUF_DEPTH_LOG),
        .CREDIT_BITS   (CREDIT_BITS)
    ) chk_i (
        .clk        (clk),
        .mrst       (mrst),
        .cmd_credit (cmd_credit),
        .enc_wr     (enc_wr),
        .pop        (pop),
        .cmd_valid  (cmd_valid),
        .fill       (fill)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // credits never exceed the words still expected, so none carry over between tests
    always @(negedge clk) begin
        cmd_credit = 1'b0;
        if (!mrst && (credits_given - valids) < exp_q.size()) begin
            if (credit_mode == 1) begin
                cmd_credit = 1'b1;
            end else if (credit_mode == 2) begin
                cmd_credit = (($urandom % 4) == 0);     // sparse single grants
            end else if (credit_mode == 3) begin
                cmd_credit = !seq_ready && (dones == starts);  // idle and short of room
            end
        end
        if (cmd_credit) begin
            credits_given++;
        end
    end

    // sequencer side monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!mrst) begin
            if (seq_done) begin
                dones++;
            end
            if (cmd_valid) begin
                valids++;
                assert (exp_q.size() != 0) else begin
                    $display("word %08h came out with no sequence outstanding", cmd_word);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_w = exp_q.pop_front();
                    assert (cmd_word == exp_w) else begin
                        $display("MISMATCH cmd_word got %08h expected %08h", cmd_word, exp_w);
                        errors++;
                    end
                end
            end
            assert (valids <= credits_given) else begin
                $display("more words issued (%0d) than credits granted (%0d)",
                         valids, credits_given);
                errors++;
            end
            assert (dones <= starts) else begin
                $display("seq_done seen without a matching start");
                errors++;
            end
        end
    end

    // {opcode, bank, address, done, pause}, msb first
    function automatic logic [31:0] pack_expected(input logic [2:0]  opc,
                                                  input logic [2:0]  bank,
                                                  input logic [14:0] addr,
                                                  input logic        done,
                                                  input logic [9:0]  pause);
        return {opc, bank, addr, done, pause};
    endfunction

    task automatic push_sequence(input bit is_wr, input logic [2:0] bank,
                                 input logic [14:0] row, input logic [6:0] col,
                                 input logic [5:0] num, input bit skip);
        int          n;
        logic [6:0]  c;
        logic [14:0] addr;
        logic [2:0]  opc;
        logic [9:0]  pre_pause;
        n         = (num == 6'd0) ? 64 : int'(num);
        opc       = is_wr ? ddr_cmd_pkg::OP_WR : ddr_cmd_pkg::OP_RD;
        pre_pause = is_wr ? ddr_cmd_pkg::T_WR_PAUSE : ddr_cmd_pkg::T_RP_PAUSE;
        exp_q.push_back(pack_expected(ddr_cmd_pkg::OP_ACT, bank, row, 1'b0,
                                      ddr_cmd_pkg::T_RCD_PAUSE));
        for (int k = 0; k < n; k++) begin
            c    = col + 7'(k);                         // wraps at 128
            addr = {(is_wr ? WSEL : RSEL), 4'b0000, c, 3'b000};
            exp_q.push_back(pack_expected(opc, bank, addr, 1'b0, ddr_cmd_pkg::RW_PAUSE));
        end
        exp_q.push_back(pack_expected(ddr_cmd_pkg::OP_PRE, bank, {14'd0, skip}, 1'b1,
                                      pre_pause));
    endtask

    // called on a falling edge, waits for seq_ready first
    task automatic issue_request(input bit is_wr, input logic [2:0] bank,
                                 input logic [14:0] row, input logic [6:0] col,
                                 input logic [5:0] num, input bit skip);
        while (!seq_ready) @(negedge clk);
        assert (!start) else begin
            $display("start high with no request pending");
            errors++;
        end
        bank_in           = bank;
        row_in            = row;
        start_col         = col;
        num128_in         = num;
        skip_next_page_in = skip;
        start_rd          = !is_wr;
        start_wr          = is_wr;
        push_sequence(is_wr, bank, row, col, num, skip);
        starts++;
        @(negedge clk);
        start_rd = 1'b0;
        start_wr = 1'b0;
        assert (start) else begin
            $display("start did not follow the request by one cycle");
            errors++;
        end
        assert (!seq_ready) else begin
            $display("seq_ready still high on the cycle after a start");
            errors++;
        end
    endtask

    task automatic random_request(input bit is_wr, input int max_len);
        logic [5:0] num;
        num = 6'(1 + ($urandom % max_len));
        issue_request(is_wr, 3'($urandom), 15'($urandom), 7'($urandom), num, 1'($urandom));
    endtask

    task automatic wait_done();
        while (dones != starts) @(negedge clk);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        if (errors == test_err_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - test_err_start);
            tests_failed++;
        end
        test_err_start = errors;
    endtask

    initial begin
        void'($urandom(32'h7a7037a7));
        mrst              = 1'b1;
        bank_in           = '0;
        row_in            = '0;
        start_col         = '0;
        num128_in         = '0;
        skip_next_page_in = 1'b0;
        start_rd          = 1'b0;
        start_wr          = 1'b0;
        repeat (8) @(negedge clk);
        mrst = 1'b0;

        assert (!cmd_valid && !seq_ready) else begin
            $display("cmd_valid or seq_ready high right after reset");
            errors++;
        end
        @(negedge clk);
        assert (seq_ready) else begin
            $display("seq_ready did not rise one cycle after reset");
            errors++;
        end
        issue_request(1'b0, 3'd1, 15'h0042, 7'd0, 6'd3, 1'b0);
        wait_done();
        repeat (10) @(negedge clk);                     // words must stay in the FIFO
        assert (valids == 0) else begin
            $display("word issued while no credit was granted");
            errors++;
        end
        credit_mode = 1;
        wait_drained();
        finish_test("reset and no-credit hold");

        issue_request(1'b0, 3'd5, 15'h1234, 7'd10, 6'd5, 1'b1);
        wait_done();
        wait_drained();
        finish_test("read sequence");

        issue_request(1'b1, 3'd2, 15'h7abc, 7'd100, 6'd0, 1'b0);  // 64 bursts, wraps
        wait_done();
        wait_drained();
        finish_test("write sequence");

        credit_mode = 0;                                // 66 words parked, past the room limit
        issue_request(1'b1, 3'd3, 15'h0101, 7'd0, 6'd0, 1'b0);
        wait_done();
        @(negedge clk);
        assert (!seq_ready) else begin
            $display("seq_ready high with no room for another full sequence");
            errors++;
        end
        credit_mode = 3;
        issue_request(1'b0, 3'd6, 15'h0202, 7'd64, 6'd0, 1'b1);   // FIFO fills to the top
        wait_done();
        credit_mode = 1;
        wait_drained();
        credit_mode = 2;
        random_request(1'b0, 12);
        random_request(1'b1, 12);
        wait_done();
        wait_drained();
        assert (valids == credits_given) else begin
            $display("credits granted and words issued differ after drain");
            errors++;
        end
        finish_test("credit back-pressure");

        credit_mode = 1;
        repeat (6) random_request(1'($urandom), 20);
        wait_done();
        wait_drained();
        assert (dones == starts) else begin
            $display("seq_done count does not match start count");
            errors++;
        end
        finish_test("mixed traffic");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/ddr_cmd_pkg.sv
hw/cmd_encod_linear_rd.sv
hw/cmd_encod_linear_wr.sv
hw/cmd_encod_linear_rw.sv
hw/cmd_seq_buf.sv
hw/linear_rw_top.sv
verif/linear_rw_chk.sv
verif/tb_linear_rw.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the linear read/write encoder testbench with Verilator.
set -u

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_linear_rw -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_linear_rw" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "** FAIL **" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
